// ==== rtl/mem_cfg_pkg.sv ====
// Subsystem sizes shared by RTL and testbench
// MEM_DEPTH must be a power of two no larger than 2**ADDR_W

`default_nettype none

package mem_cfg_pkg;

  // ----------------------------------------------------------
  // Requesters
  // ----------------------------------------------------------

  // Number of compute units on the request path
  localparam int unsigned CU_COUNT = 4;
  // Unit index width, kept at one bit for a single unit
  localparam int unsigned CU_ID_W = (CU_COUNT > 1) ? $clog2(CU_COUNT) : 1;

  // ----------------------------------------------------------
  // Memory
  // ----------------------------------------------------------

  // Word address width as seen by a unit
  localparam int unsigned ADDR_W = 10;
  // Word width
  localparam int unsigned DATA_W = 32;
  // Implemented words, addresses at or above are out of range
  localparam int unsigned MEM_DEPTH = 256;
  // Index bits actually used inside the array
  localparam int unsigned MEM_IDX_W = $clog2(MEM_DEPTH);

endpackage : mem_cfg_pkg

`default_nettype wire

// ==== rtl/mem_msg_pkg.sv ====
// Message formats on the request path
// Raw opcode codes 0 and 4..7 are illegal and decode to OP_BAD

`default_nettype none

package mem_msg_pkg;

  import mem_cfg_pkg::*;

  // ----------------------------------------------------------
  // Raw opcode codes driven by a unit
  // ----------------------------------------------------------

  localparam int unsigned OPC_W = 3;

  localparam logic [OPC_W-1:0] OPC_READ  = 3'd1;
  localparam logic [OPC_W-1:0] OPC_WRITE = 3'd2;
  localparam logic [OPC_W-1:0] OPC_FADD  = 3'd3;

  // Decoded operation
  typedef enum logic [1:0] {
    OP_READ  = 2'd0,
    OP_WRITE = 2'd1,
    OP_FADD  = 2'd2,
    OP_BAD   = 2'd3
  } mem_op_e;

  // Response status
  typedef enum logic {
    ST_OK  = 1'b0,
    ST_ERR = 1'b1
  } mem_status_e;

  // ----------------------------------------------------------
  // Payloads
  // ----------------------------------------------------------

  // Raw request as issued by a unit
  typedef struct packed {
    logic [OPC_W-1:0]  opc;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;   // write value or add operand
  } cu_req_t;

  // Decoded command, stamped with the issuing unit
  typedef struct packed {
    logic [CU_ID_W-1:0] id;
    mem_op_e            op;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  data;
  } mem_cmd_t;

  // Response routed back to the unit in id
  typedef struct packed {
    logic [CU_ID_W-1:0] id;
    mem_status_e        status;
    logic [DATA_W-1:0]  data;
  } mem_rsp_t;

endpackage : mem_msg_pkg

`default_nettype wire

// ==== rtl/cmd_decode.sv ====
// Per-unit request decoder, one registered stage
// Range check against MEM_DEPTH happens here and nowhere downstream

`timescale 1ns/100ps
`default_nettype none

module cmd_decode
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int unsigned CU_INDEX = 0
) (
  input  logic     clock,
  input  logic     rstn,
  input  logic     req_valid,
  input  cu_req_t  req,
  output logic     dec_valid,
  output mem_cmd_t dec_cmd
);

  mem_op_e op_next;

  // ----------------------------------------------------------
  // Opcode and address classification
  // ----------------------------------------------------------

  always_comb begin
    unique case (req.opc)
      OPC_READ:  op_next = OP_READ;
      OPC_WRITE: op_next = OP_WRITE;
      OPC_FADD:  op_next = OP_FADD;
      default:   op_next = OP_BAD;
    endcase
    // Out of range address turns any opcode into an error
    if (req.addr >= MEM_DEPTH) begin
      op_next = OP_BAD;
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  // Strobe follows the request by one cycle
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= req_valid;
    end
  end

  // Payload captured only with the strobe
  always_ff @(posedge clock) begin
    if (req_valid) begin
      dec_cmd.id   <= CU_ID_W'(CU_INDEX);
      dec_cmd.op   <= op_next;
      dec_cmd.addr <= req.addr;
      dec_cmd.data <= req.data;
    end
  end

endmodule : cmd_decode

`default_nettype wire

// ==== rtl/rr_arbiter.sv ====
// N-to-1 round-robin arbiter, one holding slot per input, no back-pressure
// A slot must not be strobed again before it has been granted
// Incoming strobes compete in the same cycle they arrive

`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned N         = 4
) (
  input  logic         clock,
  input  logic         rstn,
  input  logic [N-1:0] in_valid,
  input  payload_t     in_data [N],
  output logic         out_valid,
  output payload_t     out_data
);

  localparam int unsigned IDX_W = (N > 1) ? $clog2(N) : 1;

  // Holding slots
  logic [N-1:0]     slot_full;
  payload_t         slot_data [N];

  // Effective requests, slot contents or a fresh strobe
  logic [N-1:0]     req_vec;
  payload_t         cand_data [N];

  // Round-robin state and result of the search
  logic [IDX_W-1:0] last_q;
  logic             grant_found;
  logic [IDX_W-1:0] grant_idx;

  // ----------------------------------------------------------
  // Request view
  // ----------------------------------------------------------

  // Fresh strobe bypasses its slot so an idle arbiter adds one cycle only
  always_comb begin
    for (int i = 0; i < N; i++) begin
      req_vec[i]   = slot_full[i] | in_valid[i];
      cand_data[i] = in_valid[i] ? in_data[i] : slot_data[i];
    end
  end

  // ----------------------------------------------------------
  // Grant search
  // ----------------------------------------------------------

  // Start one past the last winner and wrap around
  // With N of one this collapses to a plain register stage
  always_comb begin : grant_search
    int cand;
    grant_found = 1'b0;
    grant_idx   = '0;
    for (int k = 1; k <= N; k++) begin
      cand = (int'(last_q) + k) % N;
      if (!grant_found && req_vec[cand]) begin
        grant_found = 1'b1;
        grant_idx   = IDX_W'(cand);
      end
    end
  end

  // ----------------------------------------------------------
  // Slot and pointer state
  // ----------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      slot_full <= '0;
      // Points at the last input so the first search starts at 0
      last_q    <= IDX_W'(N - 1);
    end else begin
      for (int i = 0; i < N; i++) begin
        if (grant_found && (grant_idx == IDX_W'(i))) begin
          slot_full[i] <= 1'b0;
        end else if (in_valid[i]) begin
          slot_full[i] <= 1'b1;
        end
      end
      // Winner drops to lowest priority
      if (grant_found) begin
        last_q <= grant_idx;
      end
    end
  end

  // Slot payloads, harmless if granted in the same cycle
  always_ff @(posedge clock) begin
    for (int i = 0; i < N; i++) begin
      if (in_valid[i]) begin
        slot_data[i] <= in_data[i];
      end
    end
  end

  // ----------------------------------------------------------
  // Output register
  // ----------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= grant_found;
    end
  end

  always_ff @(posedge clock) begin
    if (grant_found) begin
      out_data <= cand_data[grant_idx];
    end
  end

endmodule : rr_arbiter

`default_nettype wire

// ==== rtl/mem_execute.sv ====
// Shared word memory, one command per cycle, response one cycle later
// Array has no reset, contents are undefined until written
// Only OP_BAD may carry an out of range address

`timescale 1ns/100ps
`default_nettype none

module mem_execute
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
(
  input  logic     clock,
  input  logic     rstn,
  input  logic     cmd_valid,
  input  mem_cmd_t cmd,
  output logic     rsp_valid,
  output mem_rsp_t rsp
);

  logic [DATA_W-1:0]    mem [MEM_DEPTH];

  logic [MEM_IDX_W-1:0] word_idx;
  logic [DATA_W-1:0]    old_word;
  logic [DATA_W-1:0]    sum_word;
  mem_rsp_t             rsp_next;

  // ----------------------------------------------------------
  // Array access
  // ----------------------------------------------------------

  // Upper address bits are zero for every legal command
  assign word_idx = cmd.addr[MEM_IDX_W-1:0];
  assign old_word = mem[word_idx];
  // Wraps at DATA_W
  assign sum_word = old_word + cmd.data;

  always_ff @(posedge clock) begin
    if (cmd_valid) begin
      case (cmd.op)
        OP_WRITE: mem[word_idx] <= cmd.data;
        OP_FADD:  mem[word_idx] <= sum_word;
        default: begin
          // Read and error leave the array untouched
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Response
  // ----------------------------------------------------------

  // Every legal operation returns the word as it was before
  always_comb begin
    rsp_next.id = cmd.id;
    if (cmd.op == OP_BAD) begin
      rsp_next.status = ST_ERR;
      rsp_next.data   = '0;
    end else begin
      rsp_next.status = ST_OK;
      rsp_next.data   = old_word;
    end
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= cmd_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_valid) begin
      rsp <= rsp_next;
    end
  end

endmodule : mem_execute

`default_nettype wire

// ==== rtl/resp_router.sv ====
// 1-to-N registered router, steers each strobe to output in_id
// Unstrobed outputs hold their last payload

`timescale 1ns/100ps
`default_nettype none

module resp_router
  import mem_cfg_pkg::*;
#(
  parameter type         payload_t = logic [7:0],
  parameter int unsigned N         = 4
) (
  input  logic               clock,
  input  logic               rstn,
  input  logic               in_valid,
  input  logic [CU_ID_W-1:0] in_id,
  input  payload_t           in_data,
  output logic [N-1:0]       out_valid,
  output payload_t           out_data [N]
);

  // One-hot select of the target output
  logic [N-1:0] sel;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      sel[i] = in_valid && (in_id == CU_ID_W'(i));
    end
  end

  // ----------------------------------------------------------
  // Per-output registers
  // ----------------------------------------------------------

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      out_valid <= '0;
    end else begin
      out_valid <= sel;
    end
  end

  // Only the selected output takes the payload
  always_ff @(posedge clock) begin
    for (int i = 0; i < N; i++) begin
      if (sel[i]) begin
        out_data[i] <= in_data;
      end
    end
  end

endmodule : resp_router

`default_nettype wire

// ==== rtl/cu_mem_subsys.sv ====
// Shared-memory request path for CU_COUNT units
// One outstanding command per unit, latency 4 to 3+CU_COUNT cycles

`timescale 1ns/100ps
`default_nettype none

module cu_mem_subsys
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
(
  input  logic                clock,
  input  logic                rstn,
  input  logic [CU_COUNT-1:0] req_valid,
  input  cu_req_t             req [CU_COUNT],
  output logic [CU_COUNT-1:0] rsp_valid,
  output mem_rsp_t            rsp [CU_COUNT]
);

  // Decoder to arbiter
  logic [CU_COUNT-1:0] dec_valid;
  mem_cmd_t            dec_cmd [CU_COUNT];

  // Arbiter to execute stage
  logic                issue_valid;
  mem_cmd_t            issue_cmd;

  // Execute stage to router
  logic                exe_valid;
  mem_rsp_t            exe_rsp;

  // ----------------------------------------------------------
  // Per-unit decoders
  // ----------------------------------------------------------

  for (genvar g = 0; g < CU_COUNT; g++) begin : g_dec
    cmd_decode #(
      .CU_INDEX (g)
    ) i_cmd_decode (
      .clock     (clock),
      .rstn      (rstn),
      .req_valid (req_valid[g]),
      .req       (req[g]),
      .dec_valid (dec_valid[g]),
      .dec_cmd   (dec_cmd[g])
    );
  end

  // ----------------------------------------------------------
  // Arbitration, execution and return path
  // ----------------------------------------------------------

  rr_arbiter #(
    .payload_t (mem_cmd_t),
    .N         (CU_COUNT)
  ) i_rr_arbiter (
    .clock     (clock),
    .rstn      (rstn),
    .in_valid  (dec_valid),
    .in_data   (dec_cmd),
    .out_valid (issue_valid),
    .out_data  (issue_cmd)
  );

  mem_execute i_mem_execute (
    .clock     (clock),
    .rstn      (rstn),
    .cmd_valid (issue_valid),
    .cmd       (issue_cmd),
    .rsp_valid (exe_valid),
    .rsp       (exe_rsp)
  );

  // Requester id inside the response selects the port
  resp_router #(
    .payload_t (mem_rsp_t),
    .N         (CU_COUNT)
  ) i_resp_router (
    .clock     (clock),
    .rstn      (rstn),
    .in_valid  (exe_valid),
    .in_id     (exe_rsp.id),
    .in_data   (exe_rsp),
    .out_valid (rsp_valid),
    .out_data  (rsp)
  );

endmodule : cu_mem_subsys

`default_nettype wire

// ==== test/tb_ref_model.svh ====
// Reference model for the shared-memory path, included inside the testbench module
// Needs mem_cfg_pkg and mem_msg_pkg imported by the including module

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// ----------------------------------------------------------
// Reference memory and error bookkeeping
// ----------------------------------------------------------

logic [DATA_W-1:0] ref_mem   [MEM_DEPTH];
// Word has a defined value in the DUT array
logic              ref_known [MEM_DEPTH];

int unsigned errors = 0;
int unsigned checks = 0;

// Expected response for one request, applied to the reference memory
// known is low when the returned word was never written
function automatic mem_rsp_t ref_exec(input int unsigned unit, input cu_req_t r,
                                      output logic known);
  mem_rsp_t             res;
  logic [MEM_IDX_W-1:0] idx;
  logic [DATA_W-1:0]    old;
  idx    = r.addr[MEM_IDX_W-1:0];
  res.id = CU_ID_W'(unit);
  known  = 1'b1;
  if ((r.addr >= MEM_DEPTH) || !(r.opc inside {OPC_READ, OPC_WRITE, OPC_FADD})) begin
    // Illegal command, memory untouched
    res.status = ST_ERR;
    res.data   = '0;
  end else begin
    old        = ref_mem[idx];
    known      = ref_known[idx];
    res.status = ST_OK;
    res.data   = old;
    if (r.opc == OPC_WRITE) begin
      ref_mem[idx]   = r.data;
      ref_known[idx] = 1'b1;
    end else if (r.opc == OPC_FADD) begin
      ref_mem[idx] = old + r.data;  // wraps at DATA_W
    end
  end
  return res;
endfunction

// ----------------------------------------------------------
// Random source, 16-bit Fibonacci LFSR
// ----------------------------------------------------------

localparam logic [15:0] LFSR_SEED = 16'd34;

logic [15:0] lfsr_q = LFSR_SEED;

// Taps 16, 14, 13, 11, one step per bit
function automatic logic lfsr_bit();
  logic fb;
  fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
  lfsr_q = {lfsr_q[14:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int unsigned n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[30:0], lfsr_bit()};
  end
  return v;
endfunction

// Initial memory image, distinct for every address
function automatic logic [DATA_W-1:0] fill_word(input int unsigned a);
  return DATA_W'((a + 1) * 32'h9e37_79b9);
endfunction

// Compare and count, mismatch reported right away
task automatic check_value(input string name, input logic [63:0] exp,
                           input logic [63:0] act);
  checks++;
  if (act !== exp) begin
    $display("FAIL %s: expected 0x%0h, got 0x%0h", name, exp, act);
    errors++;
  end
endtask

`endif

// ==== test/tb_cu_mem_subsys.sv ====
// Testbench for the shared-memory request path
// One command outstanding per unit, responses checked against a reference model

`timescale 1ns/100ps
`default_nettype none

module tb_cu_mem_subsys
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
;

  // Test lengths
  localparam int unsigned WR_COUNT       = 8;
  localparam int unsigned FADD_COUNT     = 10;
  localparam int unsigned ERR_REQ        = 9;
  localparam int unsigned CONC_PER_UNIT  = 12;
  localparam int unsigned RR_REQ         = 2 * CU_COUNT + 1;
  localparam int unsigned TOTAL_REQ      = MEM_DEPTH + 2 * WR_COUNT + FADD_COUNT + 1 + ERR_REQ
                                           + CU_COUNT * CONC_PER_UNIT + RR_REQ;
  localparam int unsigned TIMEOUT_MARGIN = 200;
  localparam int unsigned CYCLE_LIMIT    = TOTAL_REQ * (3 + CU_COUNT) + TIMEOUT_MARGIN;

  // Address map of the tests
  localparam int unsigned FADD_ADDR      = 100;
  localparam int unsigned ERR_ADDR       = 110;
  localparam int unsigned REGION_BASE    = 128;
  localparam int unsigned REGION_WORDS   = 16;
  localparam int unsigned RR_BASE        = 200;

  logic                clock;
  logic                rstn;
  logic [CU_COUNT-1:0] req_valid;
  cu_req_t             req [CU_COUNT];
  logic [CU_COUNT-1:0] rsp_valid;
  mem_rsp_t            rsp [CU_COUNT];

  // Expected responses per unit, and units in order of arrival
  mem_rsp_t            exp_q   [CU_COUNT][$];
  logic                known_q [CU_COUNT][$];
  int unsigned         arrival_q [$];

  `include "tb_ref_model.svh"

  cu_mem_subsys i_dut (
    .clock     (clock),
    .rstn      (rstn),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // ----------------------------------------------------------
  // Stimulus helpers, all driving on the falling edge
  // ----------------------------------------------------------

  task automatic apply_reset();
    @(negedge clock);
    rstn = 1'b0;
    repeat (10) @(negedge clock);
    rstn = 1'b1;
  endtask

  // Queue the expected response, strobe one cycle, wait for own response
  task automatic issue(input int unsigned u, input logic [OPC_W-1:0] opc,
                       input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    cu_req_t  r;
    mem_rsp_t exp_rsp;
    logic     known;
    r.opc  = opc;
    r.addr = addr;
    r.data = data;
    @(negedge clock);
    exp_rsp = ref_exec(u, r, known);
    exp_q[u].push_back(exp_rsp);
    known_q[u].push_back(known);
    req[u]       = r;
    req_valid[u] = 1'b1;
    @(negedge clock);
    req_valid[u] = 1'b0;
    while (rsp_valid[u] !== 1'b1) begin
      @(negedge clock);
    end
  endtask

  // Every unit reads its own word in the same cycle
  task automatic issue_all_reads();
    cu_req_t  r;
    mem_rsp_t exp_rsp;
    logic     known;
    @(negedge clock);
    arrival_q.delete();
    for (int u = 0; u < CU_COUNT; u++) begin
      r.opc   = OPC_READ;
      r.addr  = ADDR_W'(RR_BASE + u);
      r.data  = '0;
      exp_rsp = ref_exec(u, r, known);
      exp_q[u].push_back(exp_rsp);
      known_q[u].push_back(known);
      req[u]  = r;
    end
    req_valid = '1;
    @(negedge clock);
    req_valid = '0;
    while (arrival_q.size() < CU_COUNT) begin
      @(negedge clock);
    end
  endtask

  // Grant order follows from the last winner before the round
  task automatic check_arrival_order(input int unsigned last);
    for (int k = 0; k < CU_COUNT; k++) begin
      check_value($sformatf("arrival_unit[%0d]", k), (last + 1 + k) % CU_COUNT, arrival_q[k]);
    end
  endtask

  // Random commands inside the unit's own region
  task automatic unit_traffic(input int unsigned u);
    logic [OPC_W-1:0]  opc;
    logic [ADDR_W-1:0] addr;
    for (int n = 0; n < CONC_PER_UNIT; n++) begin
      repeat (rand_bits(3)) @(negedge clock);
      opc  = OPC_W'(rand_bits(2) % 3 + 1);
      addr = ADDR_W'(REGION_BASE + u * REGION_WORDS + rand_bits(4));
      issue(u, opc, addr, rand_bits(32));
    end
  endtask

  // ----------------------------------------------------------
  // Response checker
  // ----------------------------------------------------------

  always @(negedge clock) begin : rsp_checker
    mem_rsp_t exp_rsp;
    logic     known;
    if (rstn) begin
      for (int u = 0; u < CU_COUNT; u++) begin
        if (rsp_valid[u] === 1'b1) begin
          arrival_q.push_back(u);
          if (exp_q[u].size() == 0) begin
            $display("ERROR: unit %0d received a response with no request outstanding", u);
            errors++;
          end else begin
            exp_rsp = exp_q[u].pop_front();
            known   = known_q[u].pop_front();
            check_value($sformatf("rsp[%0d].id", u), exp_rsp.id, rsp[u].id);
            check_value($sformatf("rsp[%0d].status", u), exp_rsp.status, rsp[u].status);
            // Data of a never written word is not predictable
            if (known) begin
              check_value($sformatf("rsp[%0d].data", u), exp_rsp.data, rsp[u].data);
            end
          end
        end
      end
    end
  end

  // Watchdog sized from the request count
  initial begin : watchdog
    int unsigned cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("Finished with %0d checks and %0d errors", checks, errors);
    $display("TESTS FAILED");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------

  initial begin : main_seq
    logic [ADDR_W-1:0] addr_list [WR_COUNT];
    int unsigned       last_winner;
    rstn      = 1'b0;
    req_valid = '0;
    for (int u = 0; u < CU_COUNT; u++) begin
      req[u] = '0;
    end
    for (int a = 0; a < MEM_DEPTH; a++) begin
      ref_known[a] = 1'b0;
    end
    apply_reset();

    // Known image of the whole array
    for (int a = 0; a < MEM_DEPTH; a++) begin
      issue(0, OPC_WRITE, ADDR_W'(a), fill_word(a));
    end

    // Write then read back from unit 0
    for (int k = 0; k < WR_COUNT; k++) begin
      addr_list[k] = ADDR_W'(rand_bits(6));
      issue(0, OPC_WRITE, addr_list[k], rand_bits(32));
    end
    for (int k = 0; k < WR_COUNT; k++) begin
      issue(0, OPC_READ, addr_list[k], '0);
    end

    // Running sums with wrap
    for (int k = 0; k < FADD_COUNT; k++) begin
      issue(1, OPC_FADD, ADDR_W'(FADD_ADDR), rand_bits(32));
    end
    issue(1, OPC_READ, ADDR_W'(FADD_ADDR), '0);

    // Bad codes, then out of range addresses that alias legal words
    for (int c = 0; c < 8; c++) begin
      if (!(c inside {[1:3]})) begin
        issue(2, OPC_W'(c), ADDR_W'(ERR_ADDR), rand_bits(32));
      end
    end
    issue(2, OPC_WRITE, ADDR_W'(MEM_DEPTH), rand_bits(32));
    issue(2, OPC_FADD, ADDR_W'(MEM_DEPTH + ERR_ADDR), rand_bits(32));
    issue(2, OPC_READ, ADDR_W'(ERR_ADDR), '0);
    issue(2, OPC_READ, '0, '0);

    // All units at once in disjoint regions
    for (int u = 0; u < CU_COUNT; u++) begin
      fork
        automatic int unsigned uu = u;
        unit_traffic(uu);
      join_none
    end
    wait fork;

    // Fairness from a fresh reset, search starts at unit 0
    apply_reset();
    last_winner = CU_COUNT - 1;
    issue_all_reads();
    check_arrival_order(last_winner);
    // A full round leaves the pointer where it was, then unit 1 wins alone
    issue(1, OPC_READ, ADDR_W'(RR_BASE + 1), '0);
    last_winner = 1;
    issue_all_reads();
    check_arrival_order(last_winner);

    repeat (4) @(negedge clock);
    for (int u = 0; u < CU_COUNT; u++) begin
      if (exp_q[u].size() != 0) begin
        $display("ERROR: unit %0d still waits for %0d responses", u, exp_q[u].size());
        errors++;
      end
    end
    $display("Finished with %0d checks and %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_cu_mem_subsys

`default_nettype wire

// ==== flist.f ====
+incdir+test
rtl/mem_cfg_pkg.sv
rtl/mem_msg_pkg.sv
rtl/cmd_decode.sv
rtl/rr_arbiter.sv
rtl/mem_execute.sv
rtl/resp_router.sv
rtl/cu_mem_subsys.sv
test/tb_cu_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: cu_mem_subsys

sources:
  - files:
      - rtl/mem_cfg_pkg.sv
      - rtl/mem_msg_pkg.sv
      - rtl/cmd_decode.sv
      - rtl/rr_arbiter.sv
      - rtl/mem_execute.sv
      - rtl/resp_router.sv
      - rtl/cu_mem_subsys.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_cu_mem_subsys.sv
